//--- mcmm_pkg.sv
package mcmm_pkg;

    // a ring slot is one 96-bit packet.
    localparam int PKT_W = 96;

    localparam int PKT_VALID     = 95;
    localparam int PKT_DST_HI    = 94;
    localparam int PKT_DST_LO    = 89;
    localparam int PKT_SRC_HI    = 88;
    localparam int PKT_SRC_LO    = 83;
    localparam int PKT_TAG_HI    = 82;
    localparam int PKT_TAG_LO    = 75;
    // bits 74..64 are reserved and travel as zero.
    localparam int PKT_PAY_HI_HI = 63;
    localparam int PKT_PAY_HI_LO = 32;
    localparam int PKT_PAY_LO_HI = 31;
    localparam int PKT_PAY_LO_LO = 0;

    typedef logic [5:0] node_num_t;

    // upper address bits that select each slave.
    localparam logic [15:0] RAM_BASE_HI = 16'h0000; // compared with adr[31:16].
    localparam logic [23:0] NET_BASE_HI = 24'hFFD800; // compared with adr[31:8].

    localparam logic [7:0] REG_TX_DST = 8'h00;
    localparam logic [7:0] REG_TX_LO  = 8'h04;
    localparam logic [7:0] REG_TX_HI  = 8'h08;
    localparam logic [7:0] REG_TX_GO  = 8'h0C;
    localparam logic [7:0] REG_STATUS = 8'h10;
    localparam logic [7:0] REG_RX_HDR = 8'h14;
    localparam logic [7:0] REG_RX_LO  = 8'h18;
    localparam logic [7:0] REG_RX_HI  = 8'h1C;
    localparam logic [7:0] REG_RX_POP = 8'h20;
    localparam logic [7:0] REG_NODE   = 8'h24;

endpackage

//--- net_fifo.sv
`timescale 1ns/1ps

module net_fifo import mcmm_pkg::*; #(
    parameter int DEPTH = 4,
    parameter int CW    = $clog2(DEPTH + 1)
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             push_i,
    input  logic             pop_i,
    input  logic [PKT_W-1:0] din_i,
    output logic [PKT_W-1:0] dout_o,
    output logic             full_o,
    output logic             empty_o,
    output logic [CW-1:0]    count_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [PKT_W-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_o == CW'(DEPTH));
    assign empty_o = (count_o == '0);
    assign do_push = push_i && !full_o; // a push into a full FIFO is lost.
    assign do_pop  = pop_i && !empty_o;
    assign dout_o  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o; // both or neither leave the fill level.
            endcase
        end
    end

endmodule

//--- net_ring_port.sv
`timescale 1ns/1ps

module net_ring_port import mcmm_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  node_num_t        node_num_i,
    input  logic [PKT_W-1:0] net_i,
    output logic [PKT_W-1:0] net_o,
    output logic             rx_push_o,
    output logic [PKT_W-1:0] rx_din_o,
    input  logic             rx_full_i,
    output logic             tx_pop_o,
    input  logic [PKT_W-1:0] tx_din_i,
    input  logic             tx_empty_i
);

    logic             in_valid;
    logic             for_me;
    logic             slot_free;
    logic [PKT_W-1:0] tx_stamped;
    logic [PKT_W-1:0] slot_next;

    assign in_valid = net_i[PKT_VALID];
    assign for_me   = in_valid && (net_i[PKT_DST_HI:PKT_DST_LO] == node_num_i);

    // a packet for this node is taken only when there is room for it.
    // otherwise it stays on the ring and comes round again.
    assign rx_push_o = for_me && !rx_full_i;
    assign rx_din_o  = net_i;

    // the slot is free if it arrived empty or was just emptied by a capture.
    assign slot_free = !in_valid || rx_push_o;
    assign tx_pop_o  = slot_free && !tx_empty_i;

    always_comb begin
        tx_stamped = tx_din_i;
        tx_stamped[PKT_VALID] = 1'b1;
        tx_stamped[PKT_SRC_HI:PKT_SRC_LO] = node_num_i; // receivers see who sent it.
    end

    always_comb begin
        if (tx_pop_o) begin
            slot_next = tx_stamped;
        end else if (slot_free) begin
            slot_next = '0; // empty slots leave as all zero.
        end else begin
            slot_next = net_i; // foreign packets and back-pressured ones pass unchanged.
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            net_o <= '0;
        end else begin
            net_o <= slot_next;
        end
    end

endmodule

//--- net_ctrl.sv
`timescale 1ns/1ps

module net_ctrl import mcmm_pkg::*; #(
    parameter int RX_DEPTH = 4,
    parameter int TX_DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  node_num_t        node_num_i,
    input  logic             cs_i,
    input  logic             cyc_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  logic [7:0]       adr_i,
    input  logic [31:0]      dat_i,
    output logic [31:0]      dat_o,
    output logic             ack_o,
    input  logic [PKT_W-1:0] net_i,
    output logic [PKT_W-1:0] net_o
);

    localparam int RX_CW = $clog2(RX_DEPTH + 1);

    logic             bus_req;
    logic             wr_en;
    logic             tx_push;
    logic             rx_pop;
    node_num_t        tx_dst;
    logic [31:0]      tx_lo;
    logic [31:0]      tx_hi;
    logic [PKT_W-1:0] tx_pkt;
    logic [PKT_W-1:0] tx_dout;
    logic             tx_full;
    logic             tx_empty;
    logic             tx_pop;
    logic [PKT_W-1:0] rx_din;
    logic [PKT_W-1:0] rx_dout;
    logic [PKT_W-1:0] rx_head;
    logic             rx_push;
    logic             rx_full;
    logic             rx_empty;
    logic [RX_CW-1:0] rx_count;
    logic [31:0]      status;

    assign bus_req = cs_i && cyc_i && stb_i;
    // writes act once, in the cycle before the acknowledge.
    assign wr_en   = bus_req && we_i && !ack_o;
    assign tx_push = wr_en && (adr_i == REG_TX_GO); // dropped by the FIFO when full.
    assign rx_pop  = wr_en && (adr_i == REG_RX_POP);

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            case (adr_i)
                REG_TX_DST: tx_dst <= dat_i[5:0];
                REG_TX_LO:  tx_lo  <= dat_i;
                REG_TX_HI:  tx_hi  <= dat_i;
                default:    ;
            endcase
        end
    end

    // valid and source are filled in by the ring port at injection.
    always_comb begin
        tx_pkt = '0;
        tx_pkt[PKT_DST_HI:PKT_DST_LO]       = tx_dst;
        tx_pkt[PKT_TAG_HI:PKT_TAG_LO]       = dat_i[7:0];
        tx_pkt[PKT_PAY_HI_HI:PKT_PAY_HI_LO] = tx_hi;
        tx_pkt[PKT_PAY_LO_HI:PKT_PAY_LO_LO] = tx_lo;
    end

    assign rx_head = rx_empty ? '0 : rx_dout;

    always_comb begin
        status = '0;
        status[0] = rx_empty;
        status[1] = tx_full;
        status[8 +: RX_CW] = rx_count;
    end

    always_comb begin
        case (adr_i)
            REG_STATUS: dat_o = status;
            REG_RX_HDR: dat_o = {18'd0, rx_head[PKT_SRC_HI:PKT_SRC_LO],
                                 rx_head[PKT_TAG_HI:PKT_TAG_LO]};
            REG_RX_LO:  dat_o = rx_head[PKT_PAY_LO_HI:PKT_PAY_LO_LO];
            REG_RX_HI:  dat_o = rx_head[PKT_PAY_HI_HI:PKT_PAY_HI_LO];
            REG_NODE:   dat_o = {26'd0, node_num_i};
            default:    dat_o = '0; // write-only registers read as zero.
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= bus_req;
        end
    end

    net_fifo #(
        .DEPTH(RX_DEPTH),
        .CW   (RX_CW)
    ) rx_fifo_inst (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .push_i (rx_push),
        .pop_i  (rx_pop),
        .din_i  (rx_din),
        .dout_o (rx_dout),
        .full_o (rx_full),
        .empty_o(rx_empty),
        .count_o(rx_count)
    );

    net_fifo #(
        .DEPTH(TX_DEPTH)
    ) tx_fifo_inst (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .push_i (tx_push),
        .pop_i  (tx_pop),
        .din_i  (tx_pkt),
        .dout_o (tx_dout),
        .full_o (tx_full),
        .empty_o(tx_empty),
        .count_o()
    );

    net_ring_port ring_port_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .node_num_i(node_num_i),
        .net_i     (net_i),
        .net_o     (net_o),
        .rx_push_o (rx_push),
        .rx_din_o  (rx_din),
        .rx_full_i (rx_full),
        .tx_pop_o  (tx_pop),
        .tx_din_i  (tx_dout),
        .tx_empty_i(tx_empty)
    );

endmodule

//--- scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        cs_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;
    logic          bus_req;

    assign idx     = adr_i[AW+1:2]; // word index, byte offset dropped.
    assign bus_req = cs_i && cyc_i && stb_i;

    always_ff @(posedge clk_i) begin
        if (bus_req) begin
            if (we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel_i[i]) begin
                        mem[idx][i*8 +: 8] <= dat_i[i*8 +: 8];
                    end
                end
            end
            dat_o <= mem[idx];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= bus_req;
        end
    end

endmodule

//--- mcmm_node.sv
`timescale 1ns/1ps

module mcmm_node import mcmm_pkg::*; #(
    parameter int RX_DEPTH  = 4,
    parameter int TX_DEPTH  = 4,
    parameter int RAM_WORDS = 1024
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  node_num_t        node_num_i,
    input  logic             cyc_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  logic [3:0]       sel_i,
    input  logic [31:0]      adr_i,
    input  logic [31:0]      dat_i,
    output logic [31:0]      dat_o,
    output logic             ack_o,
    input  logic [PKT_W-1:0] net_i,
    output logic [PKT_W-1:0] net_o
);

    logic        cs_ram;
    logic        cs_net;
    logic        cs_none;
    logic        ram_ack;
    logic [31:0] ram_dat;
    logic        net_ack;
    logic [31:0] net_dat;
    logic        none_ack;

    assign cs_ram  = (adr_i[31:16] == RAM_BASE_HI);
    assign cs_net  = (adr_i[31:8] == NET_BASE_HI);
    assign cs_none = !cs_ram && !cs_net;

    // nothing answers outside the map, so the node acknowledges it here.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= cyc_i && stb_i && cs_none;
        end
    end

    assign ack_o = ram_ack | net_ack | none_ack;

    always_comb begin
        if (cs_net) begin
            dat_o = net_dat;
        end else if (cs_ram) begin
            dat_o = ram_dat;
        end else begin
            dat_o = '0; // unmapped reads return zero.
        end
    end

    net_ctrl #(
        .RX_DEPTH(RX_DEPTH),
        .TX_DEPTH(TX_DEPTH)
    ) net_ctrl_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .node_num_i(node_num_i),
        .cs_i      (cs_net),
        .cyc_i     (cyc_i),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .adr_i     (adr_i[7:0]),
        .dat_i     (dat_i),
        .dat_o     (net_dat),
        .ack_o     (net_ack),
        .net_i     (net_i),
        .net_o     (net_o)
    );

    scratch_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) scratch_ram_inst (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .cs_i   (cs_ram),
        .cyc_i  (cyc_i),
        .stb_i  (stb_i),
        .we_i   (we_i),
        .sel_i  (sel_i),
        .adr_i  (adr_i),
        .dat_i  (dat_i),
        .dat_o  (ram_dat),
        .ack_o  (ram_ack)
    );

endmodule

//--- mcmm_node_checker.sv
`timescale 1ns/1ps

module mcmm_node_checker import mcmm_pkg::*; (
    input logic             clk_i,
    input logic             rst_n_i,
    input node_num_t        node_num_i,
    input logic             cyc_i,
    input logic             stb_i,
    input logic             ack_o,
    input logic [PKT_W-1:0] net_i,
    input logic [PKT_W-1:0] net_o
);

    logic in_foreign;
    logic out_own;

    assign in_foreign = net_i[PKT_VALID] && (net_i[PKT_DST_HI:PKT_DST_LO] != node_num_i);
    assign out_own    = net_o[PKT_VALID] && (net_o[PKT_DST_HI:PKT_DST_LO] == node_num_i);

    // every responder answers one cycle after the request it saw.
    ack_after_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_o |-> $past(cyc_i && stb_i))
        else $error("ack_o rose without a bus request in the previous cycle.");

    ack_low_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> !ack_o)
        else $error("ack_o is high during reset.");

    foreign_forwarded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_foreign |=> (net_o == $past(net_i)))
        else $error("a packet for another node was not forwarded unchanged.");

    // a packet for this node may only leave again when it was bounced back.
    own_only_bounced: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_own |-> (net_o == $past(net_i)))
        else $error("net_o carries a packet for this node that did not just arrive.");

endmodule

bind mcmm_node mcmm_node_checker mcmm_node_checker_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .node_num_i(node_num_i),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .ack_o     (ack_o),
    .net_i     (net_i),
    .net_o     (net_o)
);

//--- tb_mcmm_node.sv
`timescale 1ns/1ps

module tb_mcmm_node import mcmm_pkg::*; ();

    localparam node_num_t NODE = 6'd5;

    logic             clk_i;
    logic             rst_n_i;
    logic             cyc_i;
    logic             stb_i;
    logic             we_i;
    logic [3:0]       sel_i;
    logic [31:0]      adr_i;
    logic [31:0]      dat_i;
    logic [31:0]      dat_o;
    logic             ack_o;
    logic [PKT_W-1:0] net_i;
    logic [PKT_W-1:0] net_o;
    logic             run_closed;

    mcmm_node mcmm_node_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .node_num_i(NODE),
        .cyc_i     (cyc_i),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .sel_i     (sel_i),
        .adr_i     (adr_i),
        .dat_i     (dat_i),
        .dat_o     (dat_o),
        .ack_o     (ack_o),
        .net_i     (net_i),
        .net_o     (net_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_on_failure();
        run_closed = 1'b1;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_pkt(input string name, input logic [PKT_W-1:0] exp,
                             input logic [PKT_W-1:0] act);
        assert (act === exp) else begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    // field order follows the ring slot layout, reserved bits zero.
    function automatic logic [PKT_W-1:0] make_pkt(input logic [5:0] dst, input logic [5:0] src,
                                                  input logic [7:0] tag, input logic [31:0] hi,
                                                  input logic [31:0] lo);
        return {1'b1, dst, src, tag, 11'd0, hi, lo};
    endfunction

    function automatic logic [31:0] net_adr(input logic [7:0] offset);
        return {NET_BASE_HI, offset};
    endfunction

    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                              input logic [3:0] sel, output logic [31:0] rdat);
        int waited;
        waited = 0;
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = we;
        adr_i = adr;
        dat_i = wdat;
        sel_i = sel;
        do begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > 20) begin
                $display("timeout: host access to %h was never acknowledged", adr);
                stop_on_failure();
            end
        end while (!ack_o);
        rdat  = dat_o;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
        @(posedge clk_i); // one idle cycle lets the acknowledge fall.
        #1;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel);
        logic [31:0] unused_rd;
        bus_access(1'b1, adr, wdat, sel, unused_rd);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'd0, 4'hF, rdat);
    endtask

    // one slot goes in, and its result is on net_o one cycle later.
    task automatic ring_step(input logic [PKT_W-1:0] slot);
        net_i = slot;
        @(posedge clk_i);
        #1;
    endtask

    task automatic test_ram();
        logic [31:0] words [4];
        logic [31:0] addrs [4];
        logic [31:0] rd;
        logic [31:0] mask;
        addrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0100, 32'h0000_0FFC};
        foreach (words[i]) begin
            words[i] = $urandom();
            bus_write(addrs[i], words[i], 4'hF);
        end
        foreach (words[i]) begin
            bus_read(addrs[i], rd);
            check_word("ram readback", words[i], rd);
        end
        mask = 32'h0000_FF00; // sel 4'b0010 covers byte 1 only.
        bus_write(addrs[1], 32'hA5A5_A5A5, 4'b0010);
        bus_read(addrs[1], rd);
        check_word("ram byte write", (words[1] & ~mask) | (32'hA5A5_A5A5 & mask), rd);
    endtask

    task automatic test_forward();
        logic [PKT_W-1:0] p3;
        logic [PKT_W-1:0] p9;
        p3 = make_pkt(6'd3, 6'd1, 8'h31, $urandom(), $urandom());
        p9 = make_pkt(6'd9, 6'd1, 8'h91, $urandom(), $urandom());
        ring_step(p3);
        check_pkt("forward node 3", p3, net_o);
        ring_step(p9);
        check_pkt("forward node 9", p9, net_o);
        net_i = '0;
    endtask

    task automatic test_receive();
        logic [PKT_W-1:0] pkts [3];
        logic [31:0]      rd;
        foreach (pkts[i]) begin
            pkts[i] = make_pkt(NODE, 6'd2, 8'(8'h40 + i), $urandom(), $urandom());
            ring_step(pkts[i]);
            check_word("rx slot emptied", 32'd0, {31'd0, net_o[PKT_VALID]});
        end
        net_i = '0;
        bus_read(net_adr(REG_STATUS), rd);
        check_word("rx count", 32'd3, {24'd0, rd[15:8]});
        foreach (pkts[i]) begin
            bus_read(net_adr(REG_RX_HDR), rd);
            check_word("rx header", {18'd0, 6'd2, 8'(8'h40 + i)}, rd);
            bus_read(net_adr(REG_RX_LO), rd);
            check_word("rx low word", pkts[i][31:0], rd);
            bus_read(net_adr(REG_RX_HI), rd);
            check_word("rx high word", pkts[i][63:32], rd);
            bus_write(net_adr(REG_RX_POP), 32'd0, 4'hF);
        end
        bus_read(net_adr(REG_STATUS), rd);
        check_word("rx empty flag", 32'd1, {31'd0, rd[0]});
    endtask

    task automatic test_transmit();
        logic [PKT_W-1:0] foreign;
        logic [31:0]      lo;
        logic [31:0]      hi;
        logic [31:0]      rd;
        int               waited;
        lo      = $urandom();
        hi      = $urandom();
        foreign = make_pkt(6'd9, 6'd7, 8'h77, 32'h1111_2222, 32'h3333_4444);
        net_i   = foreign;
        bus_write(net_adr(REG_TX_DST), 32'd12, 4'hF);
        bus_write(net_adr(REG_TX_LO), lo, 4'hF);
        bus_write(net_adr(REG_TX_HI), hi, 4'hF);
        bus_write(net_adr(REG_TX_GO), 32'h0000_00C3, 4'hF);
        // busy slots keep the packet waiting in the transmit FIFO.
        repeat (2) begin
            ring_step(foreign);
            check_pkt("tx held back", foreign, net_o);
        end
        net_i  = '0;
        waited = 0;
        do begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > 20) begin
                $display("timeout: the transmit packet never appeared on the ring");
                stop_on_failure();
            end
        end while (!(net_o[PKT_VALID] && net_o[PKT_SRC_HI:PKT_SRC_LO] == NODE));
        check_word("tx slot latency", 32'd1, waited);
        check_pkt("tx packet", make_pkt(6'd12, NODE, 8'hC3, hi, lo), net_o);
        bus_read(net_adr(REG_NODE), rd);
        check_word("node number", 32'd5, rd);
    endtask

    task automatic test_backpressure();
        logic [PKT_W-1:0] pkts [5];
        logic [31:0]      rd;
        foreach (pkts[i]) begin
            pkts[i] = make_pkt(NODE, 6'd4, 8'(8'h50 + i), $urandom(), $urandom());
            ring_step(pkts[i]);
            if (i < 4) begin
                check_word("bp slot emptied", 32'd0, {31'd0, net_o[PKT_VALID]});
            end else begin
                check_pkt("bp fifth forwarded", pkts[i], net_o); // receive FIFO is full.
            end
        end
        net_i = '0;
        bus_read(net_adr(REG_STATUS), rd);
        check_word("bp rx count", 32'd4, {24'd0, rd[15:8]});
    endtask

    task automatic test_unmapped();
        logic [31:0] rd;
        bus_read(32'h8000_0000, rd);
        check_word("unmapped read", 32'd0, rd);
    endtask

    initial begin
        void'($urandom(92));
        run_closed = 1'b0;
        rst_n_i    = 1'b0;
        cyc_i      = 1'b0;
        stb_i      = 1'b0;
        we_i       = 1'b0;
        sel_i      = 4'h0;
        adr_i      = 32'd0;
        dat_i      = 32'd0;
        net_i      = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        test_ram();
        test_forward();
        test_receive();
        test_transmit();
        test_backpressure();
        test_unmapped();
        run_closed = 1'b1;
        $display("Simulation finished: PASS");
        $finish;
    end

    final begin
        if (!run_closed) begin
            $display("Simulation finished: FAIL");
        end
    end

endmodule

//--- sim.f
mcmm_pkg.sv
net_fifo.sv
net_ring_port.sv
net_ctrl.sv
scratch_ram.sv
mcmm_node.sv
mcmm_node_checker.sv
tb_mcmm_node.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the mcmm_node testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"
PASS_MSG="Simulation finished: PASS"
rm -f "$LOG"
verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_mcmm_node \
    -o tb_mcmm_node || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_mcmm_node > "$LOG" 2>&1 ; cat "$LOG"
grep -q "$FAIL_MSG" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "$PASS_MSG" "$LOG" || { echo "simulation ended without a verdict"; exit 1; }
exit 0
